// File: design/periph_pkg.sv
package periph_pkg;

    // ----------------------------------------
    // Bus widths and block map
    // ----------------------------------------
    localparam int apb_addr_width = 16;
    localparam int apb_data_width = 32;

    // Block field, paddr[15:12]
    localparam logic [3:0] blk_sel_plic  = 4'd0;
    localparam logic [3:0] blk_sel_uart  = 4'd1;
    localparam logic [3:0] blk_sel_timer = 4'd2;

    localparam int num_timers  = 2;
    localparam int num_sources = 3;
    localparam int prio_width  = 2;

    localparam int                        uart_div_width = 16;
    localparam logic [uart_div_width-1:0] uart_div_min   = 16'd2;

    // Source 1 is the UART, 2 and 3 the timers, 0 means none
    typedef logic [1:0] src_id_t;

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    typedef enum logic [3:0] {
        TIMER_CTRL   = 4'h0,
        TIMER_CMP    = 4'h4,
        TIMER_COUNT  = 4'h8,
        TIMER_STATUS = 4'hC
    } timer_reg_e;

    typedef enum logic [3:0] {
        UART_DIV    = 4'h0,
        UART_DATA   = 4'h4,
        UART_STATUS = 4'h8,
        UART_IER    = 4'hC
    } uart_reg_e;

    typedef enum logic [7:0] {
        PLIC_PRIO1     = 8'h04,
        PLIC_PRIO2     = 8'h08,
        PLIC_PRIO3     = 8'h0C,
        PLIC_ENABLE    = 8'h20,
        PLIC_THRESHOLD = 8'h24,
        PLIC_CLAIM     = 8'h28,
        PLIC_PENDING   = 8'h2C
    } plic_reg_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_SHIFT,
        UART_STOP
    } uart_state_e;

endpackage

// File: design/timer_bank.sv
module timer_bank (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  sel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [7:0]                            addr_i,
    input  logic [periph_pkg::apb_data_width-1:0] wdata_i,
    output logic [periph_pkg::apb_data_width-1:0] rdata_o,
    output logic [periph_pkg::num_timers-1:0]     irq_o
);
    import periph_pkg::*;

    logic                      win_hit;
    logic                      wr_en;
    logic                      tsel;
    timer_reg_e                reg_off;

    logic [num_timers-1:0]     en_q;
    logic [num_timers-1:0]     pend_q;
    logic [apb_data_width-1:0] cmp_q [num_timers];
    logic [apb_data_width-1:0] cnt_q [num_timers];
    logic [num_timers-1:0]     cmp_we;
    logic [num_timers-1:0]     match;

    // Two 16-byte windows, timer index in bit 4
    assign win_hit = (addr_i[7:5] == 3'b000);
    assign tsel    = addr_i[4];
    assign reg_off = timer_reg_e'(addr_i[3:0]);
    assign wr_en   = sel_i && penable_i && pwrite_i && win_hit;

    always_comb begin
        for (int i = 0; i < num_timers; i++) begin
            cmp_we[i] = wr_en && (int'(tsel) == i) && (reg_off == TIMER_CMP);
            // Also catches a count left above a lowered compare
            match[i]  = en_q[i] && (cnt_q[i] >= cmp_q[i]);
        end
    end

    // ----------------------------------------
    // Timer state
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            en_q   <= '0;
            pend_q <= '0;
            for (int i = 0; i < num_timers; i++) begin
                cmp_q[i] <= '0;
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_timers; i++) begin
                if (wr_en && (int'(tsel) == i) && (reg_off == TIMER_CTRL)) begin
                    en_q[i] <= wdata_i[0];
                end
                if (cmp_we[i]) begin
                    cmp_q[i] <= wdata_i;
                end
                if (match[i]) begin
                    cnt_q[i] <= '0;
                end else if (en_q[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                // Set wins over a clear in the same cycle
                if (match[i]) begin
                    pend_q[i] <= 1'b1;
                end else if (wr_en && (int'(tsel) == i) && (reg_off == TIMER_STATUS)
                             && wdata_i[0]) begin
                    pend_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (win_hit) begin
            case (reg_off)
                TIMER_CTRL:   rdata_o[0] = en_q[tsel];
                TIMER_CMP:    rdata_o    = cmp_q[tsel];
                TIMER_COUNT:  rdata_o    = cnt_q[tsel];
                TIMER_STATUS: rdata_o[0] = pend_q[tsel];
                default:      rdata_o    = '0;
            endcase
        end
    end

    assign irq_o = pend_q;

    // Count stays within compare once a running timer has seen its compare settle
    for (genvar i = 0; i < num_timers; i++) begin : gen_chk
        assert property (@(posedge clk_i) disable iff (reset_i)
            en_q[i] && $past(en_q[i]) && !$past(cmp_we[i]) |-> cnt_q[i] <= cmp_q[i]);
    end

endmodule

// File: design/uart_tx.sv
module uart_tx (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  sel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [7:0]                            addr_i,
    input  logic [periph_pkg::apb_data_width-1:0] wdata_i,
    output logic [periph_pkg::apb_data_width-1:0] rdata_o,
    output logic                                  tx_o,
    output logic                                  irq_o
);
    import periph_pkg::*;

    logic                      win_hit;
    logic                      wr_en;
    uart_reg_e                 reg_off;
    logic                      data_we;

    logic [uart_div_width-1:0] div_q;
    logic                      ier_q;
    uart_state_e               state_q;
    uart_state_e               state_d;
    logic [7:0]                shift_q;
    logic [7:0]                shift_d;
    logic [2:0]                bit_q;
    logic [2:0]                bit_d;
    logic [uart_div_width-1:0] baud_q;
    logic [uart_div_width-1:0] baud_d;
    logic                      baud_done;
    logic                      busy;
    logic                      tx_q;
    logic                      tx_d;

    assign win_hit   = (addr_i[7:4] == 4'h0);
    assign reg_off   = uart_reg_e'(addr_i[3:0]);
    assign wr_en     = sel_i && penable_i && pwrite_i && win_hit;
    assign data_we   = wr_en && (reg_off == UART_DATA);
    assign baud_done = (baud_q == div_q - 1'b1);
    assign busy      = (state_q != UART_IDLE);

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        shift_d = shift_q;
        bit_d   = bit_q;
        baud_d  = baud_q + 1'b1;
        case (state_q)
            UART_IDLE: begin
                baud_d = '0;
                // Writes while busy are dropped
                if (data_we) begin
                    state_d = UART_START;
                    shift_d = wdata_i[7:0];
                end
            end
            UART_START: begin
                if (baud_done) begin
                    state_d = UART_SHIFT;
                    baud_d  = '0;
                    bit_d   = '0;
                end
            end
            UART_SHIFT: begin
                if (baud_done) begin
                    baud_d  = '0;
                    shift_d = shift_q >> 1;
                    bit_d   = bit_q + 1'b1;
                    if (bit_q == 3'd7) begin
                        state_d = UART_STOP;
                    end
                end
            end
            default: begin
                if (baud_done) begin
                    state_d = UART_IDLE;
                    baud_d  = '0;
                end
            end
        endcase
    end

    // Line level for the coming cycle, LSB first
    always_comb begin
        case (state_d)
            UART_START: tx_d = 1'b0;
            UART_SHIFT: tx_d = shift_d[0];
            default:    tx_d = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= UART_IDLE;
            bit_q   <= '0;
            baud_q  <= '0;
            tx_q    <= 1'b1;
            div_q   <= uart_div_min;
            ier_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            bit_q   <= bit_d;
            baud_q  <= baud_d;
            tx_q    <= tx_d;
            if (wr_en && (reg_off == UART_DIV)) begin
                if (wdata_i[uart_div_width-1:0] < uart_div_min) begin
                    div_q <= uart_div_min;
                end else begin
                    div_q <= wdata_i[uart_div_width-1:0];
                end
            end
            if (wr_en && (reg_off == UART_IER)) begin
                ier_q <= wdata_i[0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        shift_q <= shift_d;
    end

    always_comb begin
        rdata_o = '0;
        if (win_hit) begin
            case (reg_off)
                UART_DIV:    rdata_o[uart_div_width-1:0] = div_q;
                UART_STATUS: rdata_o[0] = busy;
                UART_IER:    rdata_o[0] = ier_q;
                default:     rdata_o = '0;
            endcase
        end
    end

    assign tx_o  = tx_q;
    assign irq_o = !busy && ier_q;

    // Line idles high and the stop bit is never driven low
    assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == UART_IDLE) || (state_q == UART_STOP) |-> tx_o);

endmodule

// File: design/interrupt_controller.sv
module interrupt_controller (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  sel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [7:0]                            addr_i,
    input  logic [periph_pkg::apb_data_width-1:0] wdata_i,
    output logic [periph_pkg::apb_data_width-1:0] rdata_o,
    input  logic [periph_pkg::num_sources-1:0]    src_i,
    output logic                                  irq_o
);
    import periph_pkg::*;

    plic_reg_e              reg_off;
    logic                   wr_en;
    logic                   claim_rd;
    src_id_t                complete_id;

    logic [prio_width-1:0]  prio_q [num_sources];
    logic [num_sources-1:0] enable_q;
    logic [prio_width-1:0]  threshold_q;
    logic [num_sources-1:0] pending_q;
    logic [num_sources-1:0] claimed_q;
    logic                   irq_q;

    src_id_t                best_id;
    logic [prio_width-1:0]  best_prio;

    assign reg_off     = plic_reg_e'(addr_i);
    assign wr_en       = sel_i && penable_i && pwrite_i;
    assign claim_rd    = sel_i && penable_i && !pwrite_i && (reg_off == PLIC_CLAIM);
    assign complete_id = src_id_t'(wdata_i[1:0]);

    // ----------------------------------------
    // Highest-priority search
    // ----------------------------------------
    // Starts from the threshold, strict compare keeps the lowest ID on ties
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q;
        for (int i = 0; i < num_sources; i++) begin
            if (enable_q[i] && pending_q[i] && !claimed_q[i] && (prio_q[i] > best_prio)) begin
                best_id   = src_id_t'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < num_sources; i++) begin
                prio_q[i] <= '0;
            end
            enable_q    <= '0;
            threshold_q <= '0;
            pending_q   <= '0;
            claimed_q   <= '0;
            irq_q       <= 1'b0;
        end else begin
            irq_q <= (best_id != '0);
            // Level sources, frozen while claimed
            for (int i = 0; i < num_sources; i++) begin
                if (!claimed_q[i]) begin
                    pending_q[i] <= src_i[i];
                end
            end
            if (claim_rd && (best_id != '0)) begin
                claimed_q[best_id - 2'd1] <= 1'b1;
            end
            if (wr_en) begin
                case (reg_off)
                    PLIC_PRIO1:     prio_q[0]   <= wdata_i[prio_width-1:0];
                    PLIC_PRIO2:     prio_q[1]   <= wdata_i[prio_width-1:0];
                    PLIC_PRIO3:     prio_q[2]   <= wdata_i[prio_width-1:0];
                    PLIC_ENABLE:    enable_q    <= wdata_i[num_sources-1:0];
                    PLIC_THRESHOLD: threshold_q <= wdata_i[prio_width-1:0];
                    PLIC_CLAIM: begin
                        // Complete
                        if (complete_id != '0) begin
                            claimed_q[complete_id - 2'd1] <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_off)
            PLIC_PRIO1:     rdata_o[prio_width-1:0]  = prio_q[0];
            PLIC_PRIO2:     rdata_o[prio_width-1:0]  = prio_q[1];
            PLIC_PRIO3:     rdata_o[prio_width-1:0]  = prio_q[2];
            PLIC_ENABLE:    rdata_o[num_sources-1:0] = enable_q;
            PLIC_THRESHOLD: rdata_o[prio_width-1:0]  = threshold_q;
            PLIC_CLAIM:     rdata_o[1:0]             = best_id;
            PLIC_PENDING:   rdata_o[num_sources-1:0] = pending_q;
            default:        rdata_o                  = '0;
        endcase
    end

    assign irq_o = irq_q;

    // The ID handed out by a claim is held back from later claims
    assert property (@(posedge clk_i) disable iff (reset_i)
        claim_rd && (rdata_o[1:0] != 2'd0) |=> claimed_q[$past(rdata_o[1:0]) - 2'd1]);

endmodule

// File: design/periph_subsystem.sv
module periph_subsystem (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [periph_pkg::apb_addr_width-1:0] paddr_i,
    input  logic [periph_pkg::apb_data_width-1:0] pwdata_i,
    output logic [periph_pkg::apb_data_width-1:0] prdata_o,
    output logic                                  pready_o,
    output logic                                  pslverr_o,
    output logic                                  tx_o,
    output logic                                  irq_o
);
    import periph_pkg::*;

    logic [3:0]                blk_sel;
    logic                      plic_sel;
    logic                      uart_sel;
    logic                      timer_sel;
    logic                      unmapped;
    logic [apb_data_width-1:0] plic_rdata;
    logic [apb_data_width-1:0] uart_rdata;
    logic [apb_data_width-1:0] timer_rdata;
    logic [num_timers-1:0]     timer_irq;
    logic                      uart_irq;
    logic [num_sources-1:0]    irq_src;

    // ----------------------------------------
    // APB decode
    // ----------------------------------------
    assign blk_sel   = paddr_i[apb_addr_width-1 -: 4];
    assign plic_sel  = psel_i && (blk_sel == blk_sel_plic);
    assign uart_sel  = psel_i && (blk_sel == blk_sel_uart);
    assign timer_sel = psel_i && (blk_sel == blk_sel_timer);
    assign unmapped  = !(plic_sel || uart_sel || timer_sel);

    always_comb begin
        case (blk_sel)
            blk_sel_plic:  prdata_o = plic_rdata;
            blk_sel_uart:  prdata_o = uart_rdata;
            blk_sel_timer: prdata_o = timer_rdata;
            default:       prdata_o = '0;
        endcase
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i && penable_i && unmapped;

    // ID 1 UART, ID 2 timer 0, ID 3 timer 1
    assign irq_src = {timer_irq, uart_irq};

    timer_bank i_timer_bank (
        .clk_i     ( clk_i         ),
        .reset_i   ( reset_i       ),
        .sel_i     ( timer_sel     ),
        .penable_i ( penable_i     ),
        .pwrite_i  ( pwrite_i      ),
        .addr_i    ( paddr_i[7:0]  ),
        .wdata_i   ( pwdata_i      ),
        .rdata_o   ( timer_rdata   ),
        .irq_o     ( timer_irq     )
    );

    uart_tx i_uart_tx (
        .clk_i     ( clk_i         ),
        .reset_i   ( reset_i       ),
        .sel_i     ( uart_sel      ),
        .penable_i ( penable_i     ),
        .pwrite_i  ( pwrite_i      ),
        .addr_i    ( paddr_i[7:0]  ),
        .wdata_i   ( pwdata_i      ),
        .rdata_o   ( uart_rdata    ),
        .tx_o      ( tx_o          ),
        .irq_o     ( uart_irq      )
    );

    interrupt_controller i_interrupt_controller (
        .clk_i     ( clk_i         ),
        .reset_i   ( reset_i       ),
        .sel_i     ( plic_sel      ),
        .penable_i ( penable_i     ),
        .pwrite_i  ( pwrite_i      ),
        .addr_i    ( paddr_i[7:0]  ),
        .wdata_i   ( pwdata_i      ),
        .rdata_o   ( plic_rdata    ),
        .src_i     ( irq_src       ),
        .irq_o     ( irq_o         )
    );

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period_ns = 4;
    localparam int reset_cycles   = 4;

    initial begin
        clk_o = 1'b0;
        forever #(half_period_ns) clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// File: verification/tb_periph_subsystem.sv
module tb_periph_subsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import periph_pkg::*;

    localparam int         timeout_cycles = 20000;

    logic                      clk;
    logic                      reset;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      tx;
    logic                      irq;

    int                        cycle_cnt = 0;
    integer                    seed;
    logic [apb_data_width-1:0] cmp_val [num_timers];

    tb_clock_gen i_tb_clock_gen (
        .clk_o   ( clk   ),
        .reset_o ( reset )
    );

    periph_subsystem i_periph_subsystem (
        .clk_i     ( clk     ),
        .reset_i   ( reset   ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .tx_o      ( tx      ),
        .irq_o     ( irq     )
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            $display("Run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_data(input string name, input logic [apb_data_width-1:0] exp,
                              input logic [apb_data_width-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_state(input string name, input uart_state_e exp,
                               input uart_state_e act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // ----------------------------------------
    // APB access
    // ----------------------------------------
    function automatic logic [apb_addr_width-1:0] plic_addr(input logic [7:0] off);
        return {blk_sel_plic, 4'h0, off};
    endfunction

    function automatic logic [apb_addr_width-1:0] uart_addr(input logic [3:0] off);
        return {blk_sel_uart, 8'h00, off};
    endfunction

    function automatic logic [apb_addr_width-1:0] timer_addr(input int idx,
                                                           input logic [3:0] off);
        return {blk_sel_timer, 7'h00, idx[0], off};
    endfunction

    // Setup and access phase, read data sampled mid access cycle
    task automatic apb_access(input logic wr, input logic [apb_addr_width-1:0] addr,
                              input logic [apb_data_width-1:0] wdata,
                              output logic [apb_data_width-1:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        check_bit("pready_o", 1'b1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_addr_width-1:0] addr,
                             input logic [apb_data_width-1:0] data);
        logic [apb_data_width-1:0] rd;
        logic                      err;
        apb_access(1'b1, addr, data, rd, err);
        check_bit("pslverr_o", 1'b0, err);
    endtask

    task automatic apb_read(input logic [apb_addr_width-1:0] addr,
                            output logic [apb_data_width-1:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_bit("pslverr_o", 1'b0, err);
    endtask

    task automatic expect_read(input logic [apb_addr_width-1:0] addr,
                               input logic [apb_data_width-1:0] exp, input string name);
        logic [apb_data_width-1:0] rd;
        apb_read(addr, rd);
        check_data(name, exp, rd);
    endtask

    task automatic wait_timer_pending(input int idx);
        int                        start;
        logic [apb_data_width-1:0] st;
        start = cycle_cnt;
        st    = '0;
        while (st[0] !== 1'b1) begin
            if (cycle_cnt - start > int'(cmp_val[idx]) + 10) begin
                stop_run($sformatf("Timer %0d did not match in time", idx));
            end
            apb_read(timer_addr(idx, TIMER_STATUS), st);
        end
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int n;
        n = 0;
        while (irq !== level) begin
            if (n == limit) begin
                stop_run($sformatf("irq_o did not go to %0d within %0d cycles", level, limit));
            end
            @(negedge clk);
            n++;
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_and_unmapped();
        logic [apb_data_width-1:0] rd;
        logic                      err;
        check_bit("irq_o", 1'b0, irq);
        check_bit("tx_o", 1'b1, tx);
        expect_read(plic_addr(PLIC_ENABLE), '0, "plic enable");
        expect_read(plic_addr(PLIC_THRESHOLD), '0, "plic threshold");
        expect_read(plic_addr(PLIC_CLAIM), '0, "plic claim");
        // Block field 3 is not mapped
        apb_access(1'b0, 16'h3000, '0, rd, err);
        check_bit("pslverr_o", 1'b1, err);
        check_data("prdata_o", '0, rd);
        apb_access(1'b1, 16'h3004, 32'ha5a5_5a5a, rd, err);
        check_bit("pslverr_o", 1'b1, err);
    endtask

    task automatic test_timer_match(input int idx);
        logic [apb_data_width-1:0] rnd;
        rnd          = $random(seed);
        cmp_val[idx] = 32'd5 + (rnd % 32'd36);
        apb_write(timer_addr(idx, TIMER_CMP), cmp_val[idx]);
        expect_read(timer_addr(idx, TIMER_CMP), cmp_val[idx], "timer cmp");
        apb_write(timer_addr(idx, TIMER_CTRL), 32'd1);
        wait_timer_pending(idx);
        // Stopped so no new match lands before the clear
        apb_write(timer_addr(idx, TIMER_CTRL), 32'd0);
        apb_write(timer_addr(idx, TIMER_STATUS), 32'd1);
        expect_read(timer_addr(idx, TIMER_STATUS), 32'd0, "timer status");
    endtask

    task automatic test_uart_frame();
        logic [apb_data_width-1:0] rnd;
        logic [apb_data_width-1:0] st;
        logic [7:0]                tx_byte;
        logic                      exp_bit;
        int                        fall_cyc;
        int                        n;
        rnd     = $random(seed);
        tx_byte = rnd[7:0];
        apb_write(uart_addr(UART_DIV), 32'd4);
        apb_write(uart_addr(UART_DATA), {24'h0, tx_byte});
        n = 0;
        while (tx !== 1'b0) begin
            if (n == 8) begin
                stop_run("tx_o did not fall after the data write");
            end
            @(negedge clk);
            n++;
        end
        fall_cyc = cycle_cnt;
        // Bit k centred 4k+2 cycles after the start edge
        for (int k = 0; k < 10; k++) begin
            while (cycle_cnt < fall_cyc + 2 + 4 * k) begin
                @(negedge clk);
            end
            if (k == 0) begin
                exp_bit = 1'b0;
            end else if (k == 9) begin
                exp_bit = 1'b1;
            end else begin
                exp_bit = tx_byte[k-1];
            end
            check_bit("tx_o", exp_bit, tx);
            if (k == 0) begin
                expect_read(uart_addr(UART_STATUS), 32'd1, "uart status");
            end
        end
        n  = 0;
        st = 32'd1;
        while (st[0] !== 1'b0) begin
            if (n == 10) begin
                stop_run("UART stayed busy after the stop bit");
            end
            apb_read(uart_addr(UART_STATUS), st);
            n++;
        end
        check_bit("tx_o", 1'b1, tx);
        check_state("uart state", UART_IDLE, i_periph_subsystem.i_uart_tx.state_q);
    endtask

    task automatic test_priority();
        apb_write(plic_addr(PLIC_PRIO1), 32'd1);
        apb_write(plic_addr(PLIC_PRIO2), 32'd2);
        apb_write(plic_addr(PLIC_PRIO3), 32'd3);
        apb_write(plic_addr(PLIC_ENABLE), 32'h7);
        apb_write(plic_addr(PLIC_THRESHOLD), 32'd0);
        for (int i = 0; i < num_timers; i++) begin
            apb_write(timer_addr(i, TIMER_CTRL), 32'd1);
            wait_timer_pending(i);
            apb_write(timer_addr(i, TIMER_CTRL), 32'd0);
        end
        apb_write(uart_addr(UART_IER), 32'd1);
        wait_irq(1'b1, 4);
        expect_read(plic_addr(PLIC_PENDING), 32'h7, "plic pending");
        // Each source is quietened before its complete
        expect_read(plic_addr(PLIC_CLAIM), 32'd3, "plic claim");
        apb_write(timer_addr(1, TIMER_STATUS), 32'd1);
        apb_write(plic_addr(PLIC_CLAIM), 32'd3);
        expect_read(plic_addr(PLIC_CLAIM), 32'd2, "plic claim");
        apb_write(timer_addr(0, TIMER_STATUS), 32'd1);
        apb_write(plic_addr(PLIC_CLAIM), 32'd2);
        expect_read(plic_addr(PLIC_CLAIM), 32'd1, "plic claim");
        apb_write(uart_addr(UART_IER), 32'd0);
        apb_write(plic_addr(PLIC_CLAIM), 32'd1);
        // Long enough for a source still high to come back as irq
        repeat (4) @(negedge clk);
        check_bit("irq_o", 1'b0, irq);
        expect_read(plic_addr(PLIC_CLAIM), 32'd0, "plic claim");
    endtask

    task automatic test_threshold();
        apb_write(plic_addr(PLIC_THRESHOLD), 32'd2);
        apb_write(timer_addr(0, TIMER_CTRL), 32'd1);
        wait_timer_pending(0);
        apb_write(timer_addr(0, TIMER_CTRL), 32'd0);
        repeat (4) @(negedge clk);
        // Priority 2 does not beat threshold 2
        check_bit("irq_o", 1'b0, irq);
        expect_read(plic_addr(PLIC_CLAIM), 32'd0, "plic claim");
        apb_write(plic_addr(PLIC_THRESHOLD), 32'd1);
        wait_irq(1'b1, 4);
        expect_read(plic_addr(PLIC_CLAIM), 32'd2, "plic claim");
        expect_read(plic_addr(PLIC_CLAIM), 32'd0, "plic claim");
        apb_write(timer_addr(0, TIMER_STATUS), 32'd1);
        apb_write(plic_addr(PLIC_CLAIM), 32'd2);
        repeat (4) @(negedge clk);
        check_bit("irq_o", 1'b0, irq);
        expect_read(plic_addr(PLIC_CLAIM), 32'd0, "plic claim");
    endtask

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'hd11b_d696;
        wait (reset === 1'b0);
        @(negedge clk);
        test_reset_and_unmapped();
        test_timer_match(0);
        test_timer_match(1);
        test_uart_frame();
        test_priority();
        test_threshold();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: verilog.f
design/periph_pkg.sv
design/timer_bank.sv
design/uart_tx.sv
design/interrupt_controller.sv
design/periph_subsystem.sv
verification/tb_clock_gen.sv
verification/tb_periph_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_periph_subsystem
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
